// File: sign_path_cfg.svh
`ifndef SIGN_PATH_CFG_SVH
`define SIGN_PATH_CFG_SVH

// sign bits per macroblock and the widths that follow from it
`define SP_SIGN_MAX 64
`define SP_POS_W    6
`define SP_CNT_W    7

// fifo depths, powers of two
`define SP_MB_DEPTH 8
`define SP_UW_DEPTH 4

// almost-full levels
`define SP_MB_AFULL 6
// word fifo: three held plus one record in flight still fits
`define SP_UW_AFULL 3

`endif

// File: sign_path_pkg.sv
`include "sign_path_cfg.svh"

package sign_path_pkg;

	// 0 to 64 sign bits
	typedef logic [`SP_CNT_W-1:0] sign_count_t;

	// entry j holds signs[j] and pos[j]
	typedef struct packed {
		logic [`SP_SIGN_MAX-1:0]                signs;
		logic [`SP_SIGN_MAX-1:0][`SP_POS_W-1:0] pos;
		sign_count_t                            count;
	} mb_rec_t;

	typedef struct packed {
		logic                 sign;
		logic [`SP_POS_W-1:0] pos;
		logic                 last;
	} ser_bit_t;

	// bit k of word is the sign at original position k
	typedef struct packed {
		logic [`SP_SIGN_MAX-1:0] word;
		sign_count_t             size;
	} unscr_word_t;

	typedef struct packed {
		logic sign;
		logic last;
	} sign_out_t;

endpackage

// File: sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4,
	parameter int AFULL = 3
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] din,
	input  logic             wr,
	input  logic             rd,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             afull
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = AW + 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    fill;

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr, rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// show-ahead head entry
	assign dout  = mem[rd_ptr];
	assign empty = (fill == '0);
	assign afull = (fill >= CW'(AFULL));

	// a pop in the same cycle frees the slot
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr && !rd) |-> (fill != CW'(DEPTH))
	) else $error("sync_fifo: write while full");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd |-> !empty
	) else $error("sync_fifo: read while empty");

endmodule

// File: mb_ser.sv
`include "sign_path_cfg.svh"

module mb_ser (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sign_path_pkg::mb_rec_t   mb,
	input  logic                     mb_empty,
	input  logic                     uw_afull,
	output logic                     mb_rd,
	output sign_path_pkg::ser_bit_t  ser,
	output logic                     ser_wr
);

	sign_path_pkg::mb_rec_t     rec;
	sign_path_pkg::sign_count_t idx;
	logic                       busy;
	logic [`SP_POS_W-1:0]       sel;
	logic                       at_last;

	// new record only when idle and the word fifo has room
	assign mb_rd = !busy && !mb_empty && !uw_afull;

	always_ff @(posedge clk) begin
		if (mb_rd) begin
			rec <= mb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (mb_rd) begin
			// count of zero leaves busy low, record is dropped
			busy <= (mb.count != '0);
			idx  <= '0;
		end else if (busy) begin
			busy <= !at_last;
			idx  <= idx + 1'b1;
		end
	end

	// idx stays below 64 while busy
	assign sel     = idx[`SP_POS_W-1:0];
	assign at_last = (idx == rec.count - 1'b1);

	always_comb begin
		ser.sign = rec.signs[sel];
		ser.pos  = rec.pos[sel];
		ser.last = at_last;
	end

	// one bit per cycle, no stall inside a record
	assign ser_wr = busy;

endmodule

// File: unscrambler.sv
`include "sign_path_cfg.svh"

module unscrambler (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sign_path_pkg::ser_bit_t    ser,
	input  logic                       ser_wr,
	output sign_path_pkg::unscr_word_t uw,
	output logic                       uw_wr
);

	localparam int W = `SP_SIGN_MAX;

	logic [W-1:0]               word;
	logic [W-1:0]               word_nxt;
	logic [W-1:0]               mask;
	logic [W-1:0]               mask_nxt;
	sign_path_pkg::sign_count_t cnt;
	logic                       done;

	// current bit placed at its original position
	always_comb begin
		word_nxt          = word;
		word_nxt[ser.pos] = ser.sign;
		mask_nxt          = mask | (W'(1) << ser.pos);
	end

	assign done = ser_wr && ser.last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word  <= '0;
			mask  <= '0;
			cnt   <= '0;
			uw_wr <= 1'b0;
		end else begin
			uw_wr <= done;
			if (done) begin
				word <= '0;
				mask <= '0;
				cnt  <= '0;
			end else if (ser_wr) begin
				word <= word_nxt;
				mask <= mask_nxt;
				cnt  <= cnt + 1'b1;
			end
		end
	end

	// finished word goes out the cycle after last
	always_ff @(posedge clk) begin
		if (done) begin
			uw.word <= word_nxt;
			uw.size <= cnt + 1'b1;
		end
	end

	a_pos_once: assert property (
		@(posedge clk) disable iff (!rst_n)
		ser_wr |-> !mask[ser.pos]
	) else $error("unscrambler: position filled twice in one macroblock");

	// positions of a macroblock cover 0 to size-1 exactly
	a_pos_dense: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> (mask_nxt == ~({W{1'b1}} << (cnt + 1'b1)))
	) else $error("unscrambler: positions are not a permutation of 0 to size-1");

endmodule

// File: post_unscr_ser.sv
`include "sign_path_cfg.svh"

module post_unscr_ser (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sign_path_pkg::unscr_word_t uw,
	input  logic                       uw_empty,
	input  logic                       bit_afull,
	output logic                       uw_rd,
	output sign_path_pkg::sign_out_t   sign,
	output logic                       sign_wr
);

	localparam sign_path_pkg::sign_count_t LAST_REM = 1;

	logic                       busy;
	logic [`SP_SIGN_MAX-1:0]    shreg;
	sign_path_pkg::sign_count_t rem;
	logic                       step;

	assign uw_rd = !busy && !uw_empty;
	// hold while downstream is almost full
	assign step  = busy && !bit_afull;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			rem     <= '0;
			sign_wr <= 1'b0;
		end else begin
			sign_wr <= step;
			if (uw_rd) begin
				busy <= (uw.size != '0);
				rem  <= uw.size;
			end else if (step) begin
				busy <= (rem != LAST_REM);
				rem  <= rem - 1'b1;
			end
		end
	end

	// lsb first, bit 0 is original position 0
	always_ff @(posedge clk) begin
		if (uw_rd) begin
			shreg <= uw.word;
		end else if (step) begin
			shreg <= shreg >> 1;
		end
		if (step) begin
			sign.sign <= shreg[0];
			sign.last <= (rem == LAST_REM);
		end
	end

endmodule

// File: sign_path.sv
`include "sign_path_cfg.svh"

module sign_path (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sign_path_pkg::mb_rec_t   mb,
	input  logic                     mb_wr,
	output logic                     mb_afull,
	input  logic                     bit_afull,
	output sign_path_pkg::sign_out_t sign,
	output logic                     sign_wr
);

	sign_path_pkg::mb_rec_t      mb_head;
	logic                        mb_empty;
	logic                        mb_rd;

	sign_path_pkg::ser_bit_t     ser;
	logic                        ser_wr;

	sign_path_pkg::unscr_word_t  uw;
	logic                        uw_wr;
	sign_path_pkg::unscr_word_t  uw_head;
	logic                        uw_empty;
	logic                        uw_afull;
	logic                        uw_rd;

	sync_fifo #(
		.WIDTH ($bits(sign_path_pkg::mb_rec_t)),
		.DEPTH (`SP_MB_DEPTH),
		.AFULL (`SP_MB_AFULL)
	) mb_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (mb),
		.wr    (mb_wr),
		.rd    (mb_rd),
		.dout  (mb_head),
		.empty (mb_empty),
		.afull (mb_afull)
	);

	mb_ser mb_ser_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.mb       (mb_head),
		.mb_empty (mb_empty),
		.uw_afull (uw_afull),
		.mb_rd    (mb_rd),
		.ser      (ser),
		.ser_wr   (ser_wr)
	);

	unscrambler unscrambler_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.ser    (ser),
		.ser_wr (ser_wr),
		.uw     (uw),
		.uw_wr  (uw_wr)
	);

	// afull here throttles mb_ser before the word fifo can overflow
	sync_fifo #(
		.WIDTH ($bits(sign_path_pkg::unscr_word_t)),
		.DEPTH (`SP_UW_DEPTH),
		.AFULL (`SP_UW_AFULL)
	) uw_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (uw),
		.wr    (uw_wr),
		.rd    (uw_rd),
		.dout  (uw_head),
		.empty (uw_empty),
		.afull (uw_afull)
	);

	post_unscr_ser post_unscr_ser_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.uw        (uw_head),
		.uw_empty  (uw_empty),
		.bit_afull (bit_afull),
		.uw_rd     (uw_rd),
		.sign      (sign),
		.sign_wr   (sign_wr)
	);

endmodule

// File: tb_sign_path.sv
`include "sign_path_cfg.svh"

module tb_sign_path;

	localparam int WAIT_LIMIT  = 5000;
	localparam int DRAIN_LIMIT = 40000;

	logic                     clk;
	logic                     rst_n;
	sign_path_pkg::mb_rec_t   mb;
	logic                     mb_wr;
	logic                     mb_afull;
	logic                     bit_afull;
	sign_path_pkg::sign_out_t sign;
	logic                     sign_wr;

	// bit_afull source select
	logic rand_afull;
	logic hold_afull;
	logic prev_afull = 1'b0;

	sign_path_pkg::sign_out_t   exp_q[$];
	sign_path_pkg::sign_count_t exp_cnt_q[$];
	sign_path_pkg::sign_count_t bits_seen;
	int                         wr_seen;
	int                         errors;
	int                         tests_run;
	int                         tests_failed;
	int                         test_err0;
	string                      cur_test;

	sign_path UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.mb        (mb),
		.mb_wr     (mb_wr),
		.mb_afull  (mb_afull),
		.bit_afull (bit_afull),
		.sign      (sign),
		.sign_wr   (sign_wr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		bit_afull <= rand_afull ? ($urandom % 4 == 0) : hold_afull;
	end

	task automatic check_sign(input sign_path_pkg::sign_out_t exp,
		input sign_path_pkg::sign_out_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: sign bit expected sign=%b last=%b, actual sign=%b last=%b",
				cur_test, exp.sign, exp.last, act.sign, act.last);
			errors++;
		end
	endtask

	task automatic check_count(input sign_path_pkg::sign_count_t exp,
		input sign_path_pkg::sign_count_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: bits per macroblock expected %0d, actual %0d",
				cur_test, exp, act);
			errors++;
		end
	endtask

	// output monitor, values sampled before the edge updates them
	always @(posedge clk) begin : monitor
		sign_path_pkg::sign_out_t e;
		if (rst_n) begin
			if (prev_afull && sign_wr) begin
				$display("[ERROR] %s: sign_wr pulsed while bit_afull was held high", cur_test);
				errors++;
			end
			if (sign_wr) begin
				wr_seen++;
				bits_seen++;
				if (exp_q.size() == 0) begin
					$display("[ERROR] %s: sign_wr pulsed with no sign bit expected", cur_test);
					errors++;
				end else begin
					e = exp_q.pop_front();
					check_sign(e, sign);
				end
				if (sign.last) begin
					if (exp_cnt_q.size() == 0) begin
						$display("[ERROR] %s: last flag seen with no macroblock expected",
							cur_test);
						errors++;
					end else begin
						check_count(exp_cnt_q.pop_front(), bits_seen);
					end
					bits_seen = '0;
				end
			end
		end
		prev_afull = bit_afull;
	end

	// random signs, first n positions shuffled from 0..n-1
	function automatic sign_path_pkg::mb_rec_t make_rec(input int n, input bit identity);
		sign_path_pkg::mb_rec_t r;
		int perm[`SP_SIGN_MAX];
		int j;
		int t;
		r.signs = {$urandom, $urandom};
		r.count = sign_path_pkg::sign_count_t'(n);
		for (int i = 0; i < `SP_SIGN_MAX; i++) begin
			perm[i] = i;
		end
		if (!identity) begin
			for (int i = n - 1; i > 0; i--) begin
				j = $urandom % (i + 1);
				t = perm[i];
				perm[i] = perm[j];
				perm[j] = t;
			end
		end
		for (int i = 0; i < `SP_SIGN_MAX; i++) begin
			if (i < n) begin
				r.pos[i] = `SP_POS_W'(perm[i]);
			end else begin
				r.pos[i] = `SP_POS_W'($urandom);
			end
		end
		return r;
	endfunction

	// bit k of the output is the sign whose position is k
	function automatic void model_push(input sign_path_pkg::mb_rec_t r);
		logic [`SP_SIGN_MAX-1:0]  ordered;
		sign_path_pkg::sign_out_t e;
		int                       n;
		n = int'(r.count);
		ordered = '0;
		for (int j = 0; j < n; j++) begin
			ordered[r.pos[j]] = r.signs[j];
		end
		for (int k = 0; k < n; k++) begin
			e.sign = ordered[k];
			e.last = (k == n - 1);
			exp_q.push_back(e);
		end
		if (n > 0) begin
			exp_cnt_q.push_back(r.count);
		end
	endfunction

	task automatic write_rec(input sign_path_pkg::mb_rec_t r);
		int waited;
		waited = 0;
		@(posedge clk);
		while (mb_afull && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (mb_afull) begin
			$display("[ERROR] %s: mb_afull stayed high, record could not be written", cur_test);
			errors++;
		end else begin
			model_push(r);
			mb    <= r;
			mb_wr <= 1'b1;
			@(posedge clk);
			mb_wr <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("[ERROR] %s: timed out with %0d sign bits still missing",
				cur_test, exp_q.size());
			errors++;
		end
		// idle cycles catch stray bits
		repeat (16) @(posedge clk);
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_err0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_err0);
		end
	endtask

	initial begin : stimulus
		int n;
		int sent;
		int wr_start;
		bit full_seen;
		void'($urandom(50));
		rst_n        = 1'b0;
		mb           = '0;
		mb_wr        = 1'b0;
		bit_afull    = 1'b0;
		rand_afull   = 1'b0;
		hold_afull   = 1'b0;
		bits_seen    = '0;
		wr_seen      = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "reset";
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		start_test("reset");
		repeat (12) begin
			@(posedge clk);
			if (sign_wr || mb_afull) begin
				$display("[ERROR] %s: sign_wr or mb_afull high before any write", cur_test);
				errors++;
			end
		end
		finish_test();

		start_test("identity");
		write_rec(make_rec(64, 1'b1));
		wait_drain();
		finish_test();

		start_test("random_perm");
		rand_afull <= 1'b1;
		for (int i = 0; i < 200; i++) begin
			n = 1 + ($urandom % 64);
			write_rec(make_rec(n, 1'b0));
		end
		wait_drain();
		rand_afull <= 1'b0;
		finish_test();

		start_test("zero_count");
		write_rec(make_rec(0, 1'b0));
		for (int i = 0; i < 40; i++) begin
			if ($urandom % 3 == 0) begin
				n = 0;
			end else begin
				n = 1 + ($urandom % 64);
			end
			write_rec(make_rec(n, 1'b0));
		end
		wait_drain();
		finish_test();

		// fill everything behind a held bit_afull
		start_test("back_pressure");
		hold_afull <= 1'b1;
		repeat (2) @(posedge clk);
		wr_start  = wr_seen;
		sent      = 0;
		full_seen = 1'b0;
		while (!full_seen && sent < 40) begin
			@(posedge clk);
			if (mb_afull) begin
				full_seen = 1'b1;
			end else begin
				write_rec(make_rec(1 + ($urandom % 64), 1'b0));
				sent++;
			end
		end
		if (!full_seen) begin
			$display("[ERROR] %s: mb_afull never rose with bit_afull held high", cur_test);
			errors++;
		end
		repeat (8) @(posedge clk);
		if (wr_seen - wr_start > 1) begin
			$display("[ERROR] %s: %0d sign bits came out while bit_afull was held high",
				cur_test, wr_seen - wr_start);
			errors++;
		end
		hold_afull <= 1'b0;
		wait_drain();
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+.
sign_path_pkg.sv
sync_fifo.sv
mb_ser.sv
unscrambler.sv
post_unscr_ser.sv
sign_path.sv
tb_sign_path.sv

// File: Bender.yml
package:
  name: sign_path

export_include_dirs:
  - .

sources:
  - sign_path_pkg.sv
  - sync_fifo.sv
  - mb_ser.sv
  - unscrambler.sv
  - post_unscr_ser.sv
  - sign_path.sv
  - target: test
    files:
      - tb_sign_path.sv
